// ==== Makefile ====
# Verilator build for the download loader testbench

TOP := tb_vic_loader

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== load_decode.sv ====
/*
 * Download decode stage
 * Picks the download kind from the file index, registers each
 * byte with its kind and flags the kind of a download that has
 * just ended
 */
`timescale 1ns/1ns

module load_decode (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  vic_load_pkg::dl_req_t  dl_i,
    output vic_load_pkg::dl_beat_t beat_o,
    output vic_load_pkg::dl_kind_t dl_end_o
);

    vic_load_pkg::dl_kind_t kind;
    vic_load_pkg::dl_kind_t kind_q;
    vic_load_pkg::dl_kind_t end_q;
    logic                   strobe_q;
    logic [24:0]            offset_q;
    logic [7:0]             data_q;

    // Kind only while the download flag is up
    always_comb begin
        kind = vic_load_pkg::DL_NONE;
        if (dl_i.active) begin
            case (dl_i.index)
                vic_load_pkg::IDX_ROM:      kind = vic_load_pkg::DL_ROM;
                vic_load_pkg::IDX_PRG_A,
                vic_load_pkg::IDX_PRG_B:    kind = vic_load_pkg::DL_PRG;
                vic_load_pkg::IDX_TAP:      kind = vic_load_pkg::DL_TAP;
                vic_load_pkg::IDX_MEGACART: kind = vic_load_pkg::DL_MC;
                default:                    kind = vic_load_pkg::DL_NONE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            kind_q   <= vic_load_pkg::DL_NONE;
            end_q    <= vic_load_pkg::DL_NONE;
            strobe_q <= 1'b0;
        end else begin
            kind_q   <= kind;
            // Unknown indexes produce no beats
            strobe_q <= dl_i.strobe && (kind != vic_load_pkg::DL_NONE);
            // Previous kind gone means that download finished
            if (kind_q != kind) begin
                end_q <= kind_q;
            end else begin
                end_q <= vic_load_pkg::DL_NONE;
            end
        end
    end

    // Byte payload
    always_ff @(posedge clk_sys) begin
        offset_q <= dl_i.offset;
        data_q   <= dl_i.data;
    end

    assign beat_o = '{
        kind:   kind_q,
        strobe: strobe_q,
        offset: offset_q,
        data:   data_q
    };

    assign dl_end_o = end_q;

endmodule

// ==== load_execute.sv ====
/*
 * Address execution stage
 * Turns each beat into a target address with the ROM map and the
 * PRG and TAP counters, and after a PRG load writes the end
 * address into the zero-page pointers
 */
`timescale 1ns/1ns

module load_execute #(
    parameter logic [mem_port_pkg::MEM_AW-1:0] TAP_START = 23'h20000
) (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   no_header_i,
    input  vic_load_pkg::dl_beat_t beat_i,
    input  vic_load_pkg::dl_kind_t dl_end_i,
    output mem_port_pkg::mem_wr_t  wr_o,
    output logic                   inject_o,
    output logic                   autostart_o,
    output logic                   mc_end_o
);

    localparam int AW = mem_port_pkg::MEM_AW;

    logic [15:0]   prg_addr;
    logic [AW-1:0] tap_addr;
    logic [4:0]    inj_state;
    logic          auto_armed;

    logic [15:0]   prg_next;
    logic [AW-1:0] tap_next;
    logic [AW-1:0] rom_addr;
    logic          rom_ok;
    logic          prg_hdr;
    logic          inj_slot;

    logic          valid_q;
    logic          inject_q;
    logic          autostart_q;
    logic          mc_end_q;
    logic [AW-1:0] addr_q;
    logic [7:0]    data_q;
    logic          rom_q;
    logic          bank_q;

    // ==================================================
    // Address calculation
    // ==================================================
    always_comb begin
        rom_ok = beat_i.offset < 25'h000B000;
        case (beat_i.offset[15:13])
            3'b000, 3'b001: rom_addr = {9'h000, beat_i.offset[13:0]};        // Drive
            3'b010:         rom_addr = {7'h00, 3'b111, beat_i.offset[12:0]}; // PAL kernal
            3'b011:         rom_addr = {7'h01, 3'b111, beat_i.offset[12:0]}; // NTSC kernal
            3'b100:         rom_addr = {7'h00, 3'b110, beat_i.offset[12:0]}; // BASIC
            default:        rom_addr = {7'h00, 4'b1000, beat_i.offset[11:0]};
        endcase
    end

    always_comb begin
        prg_hdr = !no_header_i && (beat_i.offset < 25'd2);
        if (no_header_i && (beat_i.offset == '0)) begin
            prg_next = vic_load_pkg::PRG_NOHDR_BASE;
        end else if (!no_header_i && (beat_i.offset == 25'd2)) begin
            prg_next = prg_addr;
        end else if (prg_addr == vic_load_pkg::PRG_LIMIT) begin
            prg_next = prg_addr;
        end else begin
            prg_next = prg_addr + 16'd1;
        end
        tap_next = (beat_i.offset == '0) ? TAP_START : tap_addr + AW'(1);
    end

    // Odd states 1 to 15 own the write port
    assign inj_slot = inj_state[0] && !inj_state[4];

    // ==================================================
    // Counters and pointer sequencer
    // ==================================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prg_addr    <= '0;
            tap_addr    <= TAP_START;
            inj_state   <= '0;
            auto_armed  <= 1'b0;
            valid_q     <= 1'b0;
            inject_q    <= 1'b0;
            autostart_q <= 1'b0;
            mc_end_q    <= 1'b0;
        end else begin
            valid_q     <= 1'b0;
            autostart_q <= 1'b0;
            inject_q    <= inj_slot;
            mc_end_q    <= (dl_end_i == vic_load_pkg::DL_MC);
            if (beat_i.strobe) begin
                case (beat_i.kind)
                    vic_load_pkg::DL_PRG: begin
                        if (prg_hdr) begin
                            if (beat_i.offset[0]) begin
                                prg_addr[15:8] <= beat_i.data;
                            end else begin
                                prg_addr[7:0] <= beat_i.data;
                            end
                        end else begin
                            prg_addr <= prg_next;
                            valid_q  <= 1'b1;
                            if (prg_next == vic_load_pkg::PRG_NOHDR_BASE) begin
                                auto_armed <= 1'b1;
                            end
                        end
                    end
                    vic_load_pkg::DL_TAP: begin
                        tap_addr <= tap_next;
                        valid_q  <= 1'b1;
                    end
                    vic_load_pkg::DL_ROM: valid_q <= rom_ok;
                    vic_load_pkg::DL_MC:  valid_q <= 1'b1;
                    default:              valid_q <= 1'b0;
                endcase
            end
            if (inj_slot) begin
                valid_q <= 1'b1;
            end
            // Last state fires the cartridge autostart
            if (inj_state == 5'd31) begin
                autostart_q <= auto_armed;
                auto_armed  <= 1'b0;
            end
            if (dl_end_i == vic_load_pkg::DL_PRG) begin
                inj_state <= 5'd1;
            end else if (inj_state != '0) begin
                inj_state <= inj_state + 5'd1;
            end
        end
    end

    // Write payload with pointer bytes alternating low then high
    always_ff @(posedge clk_sys) begin
        if (inj_slot) begin
            addr_q <= {{(AW - 16){1'b0}}, vic_load_pkg::INJECT_PTRS[inj_state[3:1]]};
            data_q <= inj_state[1] ? prg_addr[15:8] : prg_addr[7:0];
            rom_q  <= 1'b0;
            bank_q <= 1'b0;
        end else begin
            data_q <= beat_i.data;
            rom_q  <= (beat_i.kind == vic_load_pkg::DL_ROM);
            bank_q <= (beat_i.kind == vic_load_pkg::DL_MC);
            case (beat_i.kind)
                vic_load_pkg::DL_PRG: addr_q <= {{(AW - 16){1'b0}}, prg_next};
                vic_load_pkg::DL_TAP: addr_q <= tap_next;
                vic_load_pkg::DL_ROM: addr_q <= rom_addr;
                default:              addr_q <= beat_i.offset[AW-1:0];
            endcase
        end
    end

    // Internal field still marks a ROM image byte here
    assign wr_o = '{
        valid:    valid_q,
        addr:     addr_q,
        data:     data_q,
        internal: rom_q,
        bank:     bank_q
    };

    assign inject_o    = inject_q;
    assign autostart_o = autostart_q;
    assign mc_end_o    = mc_end_q;

endmodule

// ==== load_result.sv ====
/*
 * Write result stage
 * Decides whether each write lands in core memory or SDRAM,
 * registers the write port and drives the soft reset pulse
 */
`timescale 1ns/1ns

module load_result (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  mem_port_pkg::mem_wr_t wr_i,
    input  logic                  inject_i,
    input  logic                  autostart_i,
    input  logic                  mc_end_i,
    output mem_port_pkg::mem_wr_t mem_wr_o,
    output logic                  force_reset_o
);

    logic        low_space;
    logic        prg_space;
    logic        internal;

    logic        valid_q;
    logic        force_q;
    logic [mem_port_pkg::MEM_AW-1:0] addr_q;
    logic [7:0]  data_q;
    logic        internal_q;
    logic        bank_q;

    // Incoming internal bit is the ROM image marker
    always_comb begin
        low_space = (wr_i.addr[22:16] == '0);
        prg_space = low_space && !wr_i.internal && !wr_i.bank;
        internal  = inject_i
            || (wr_i.internal && low_space && (wr_i.addr[15:13] == 3'b100))
            || (prg_space && ((wr_i.addr[15:10] == 6'b000000)      // Low RAM
                           || (wr_i.addr[15:12] == 4'h1)          // Main RAM
                           || (wr_i.addr[15:10] == 6'b100101)));  // Colour RAM
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            valid_q <= 1'b0;
            force_q <= 1'b0;
        end else begin
            valid_q <= wr_i.valid;
            force_q <= autostart_i || mc_end_i;
        end
    end

    always_ff @(posedge clk_sys) begin
        addr_q     <= wr_i.addr;
        data_q     <= wr_i.data;
        internal_q <= internal;
        bank_q     <= wr_i.bank;
    end

    assign mem_wr_o = '{
        valid:    valid_q,
        addr:     addr_q,
        data:     data_q,
        internal: internal_q,
        bank:     bank_q
    };

    assign force_reset_o = force_q;

endmodule

// ==== mem_port_pkg.sv ====
/*
 * Memory write port
 * Address width and the write struct shared by the loader
 * stages and the memory side
 */
package mem_port_pkg;

    localparam int MEM_AW = 23;

    // One byte write towards core memory or SDRAM
    typedef struct packed {
        logic              valid;
        logic [MEM_AW-1:0] addr;
        logic [7:0]        data;
        logic              internal;
        logic              bank;
    } mem_wr_t;

endpackage

// ==== sim.f ====
vic_load_pkg.sv
mem_port_pkg.sv
load_decode.sv
load_execute.sv
load_result.sv
vic_loader_top.sv
tb_vic_loader.sv

// ==== tb_vic_loader.sv ====
/*
 * Testbench for the download loader
 * Drives ROM, PRG, TAP and Megacart downloads into the DUT, builds
 * the expected memory writes with a reference model and compares
 * every write, its latency and the soft reset pulses
 */
`timescale 1ns/1ns

module tb_vic_loader;

    localparam logic [22:0] TAP_START = 23'h20000;
    localparam int ROM_FIXED     = 12;
    localparam int ROM_BYTES     = ROM_FIXED + 16;
    localparam int PRG_HDR_BYTES = 22;
    localparam int PRG_RAW_BYTES = 8200;
    localparam int TAP_BYTES     = 24;
    localparam int MC_BYTES      = 16;
    localparam int BURST_BYTES   = 16;
    localparam int TOTAL_BYTES   = ROM_BYTES + PRG_HDR_BYTES + PRG_RAW_BYTES
                                 + TAP_BYTES + MC_BYTES + BURST_BYTES;

    // One sample per ROM region and its edges
    localparam logic [24:0] ROM_OFFS [ROM_FIXED] = '{
        25'h0000, 25'h1234, 25'h3FFF, 25'h4000, 25'h5FFF, 25'h6000,
        25'h7ABC, 25'h8000, 25'h9FFF, 25'hA000, 25'hA7FF, 25'hAFFF
    };

    // BASIC start and end pointers in zero page
    localparam logic [15:0] PTR_ADDR [8] = '{
        16'h002D, 16'h002E, 16'h002F, 16'h0030,
        16'h0031, 16'h0032, 16'h00AE, 16'h00AF
    };

    typedef struct packed {
        mem_port_pkg::mem_wr_t wr;
        logic [31:0]           due;
    } exp_t;

    logic                   clk_sys = 1'b0;
    logic                   reset;
    vic_load_pkg::dl_req_t  dl;
    logic                   no_header;
    mem_port_pkg::mem_wr_t  mem_wr;
    logic                   force_reset;

    exp_t                   exp_q [$];
    exp_t                   got;
    logic [31:0]            cycle = '0;
    logic [31:0]            rng_state;
    int                     errors = 0;
    int                     checks = 0;
    int                     force_count = 0;
    vic_load_pkg::dl_kind_t cur_kind;
    logic [15:0]            ref_prg;
    logic                   ref_armed;

    vic_loader_top #(
        .TAP_START (TAP_START)
    ) vic_loader_top_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .dl_i          (dl),
        .no_header_i   (no_header),
        .mem_wr_o      (mem_wr),
        .force_reset_o (force_reset)
    );

    always #4 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle <= cycle + 32'd1;
    end

    always @(negedge clk_sys) begin
        if (!reset && force_reset) begin
            force_count <= force_count + 1;
        end
    end

    function logic [31:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // ==================================================
    // Reference model
    // ==================================================
    function mem_port_pkg::mem_wr_t expected_wr(input vic_load_pkg::dl_kind_t kind,
                                                input logic [24:0] offset,
                                                input logic [7:0] data,
                                                input logic no_hdr);
        mem_port_pkg::mem_wr_t wr;
        wr       = '0;
        wr.valid = 1'b1;
        wr.data  = data;
        case (kind)
            vic_load_pkg::DL_ROM: begin
                if (offset < 25'h4000) begin
                    wr.addr = 23'(offset);
                end else if (offset < 25'h6000) begin
                    wr.addr = 23'h00E000 + 23'(offset - 25'h4000);
                end else if (offset < 25'h8000) begin
                    wr.addr = 23'h01E000 + 23'(offset - 25'h6000);
                end else if (offset < 25'hA000) begin
                    wr.addr = 23'h00C000 + 23'(offset - 25'h8000);
                end else begin
                    // Character ROM sits in core memory
                    wr.addr     = 23'h008000 + 23'(offset - 25'hA000);
                    wr.internal = 1'b1;
                end
            end
            vic_load_pkg::DL_PRG: begin
                if (!no_hdr && offset < 25'd2) begin
                    if (offset == 25'd1) begin
                        ref_prg[15:8] = data;
                    end else begin
                        ref_prg[7:0] = data;
                    end
                    wr.valid = 1'b0;
                end else begin
                    if (no_hdr && offset == 25'd0) begin
                        ref_prg = 16'hA000;
                    end else if ((no_hdr || offset != 25'd2) && ref_prg != 16'hBFFF) begin
                        ref_prg = ref_prg + 16'd1;
                    end
                    if (ref_prg == 16'hA000) begin
                        ref_armed = 1'b1;
                    end
                    wr.addr     = {7'h00, ref_prg};
                    wr.internal = (ref_prg < 16'h0400)
                        || (ref_prg >= 16'h1000 && ref_prg <= 16'h1FFF)
                        || (ref_prg >= 16'h9400 && ref_prg <= 16'h97FF);
                end
            end
            vic_load_pkg::DL_TAP: wr.addr = TAP_START + offset[22:0];
            vic_load_pkg::DL_MC: begin
                wr.addr = offset[22:0];
                wr.bank = 1'b1;
            end
            default: wr.valid = 1'b0;
        endcase
        return wr;
    endfunction

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task start_dl(input logic [7:0] index, input vic_load_pkg::dl_kind_t kind,
                  input logic no_hdr);
        @(posedge clk_sys);
        #1;
        dl.active    = 1'b1;
        dl.index     = index;
        dl.strobe    = 1'b0;
        no_header    = no_hdr;
        cur_kind     = kind;
        ref_armed    = 1'b0;
    endtask

    // Strobe stays up until the next task drives the bus
    task send_beat(input logic [24:0] offset, input logic [7:0] data);
        mem_port_pkg::mem_wr_t wr;
        exp_t                  e;
        @(posedge clk_sys);
        #1;
        dl.strobe = 1'b1;
        dl.offset = offset;
        dl.data   = data;
        wr = expected_wr(cur_kind, offset, data, no_header);
        if (wr.valid) begin
            e.wr  = wr;
            e.due = cycle + 32'd3;
            exp_q.push_back(e);
        end
    endtask

    task send_gap(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            #1;
            dl.strobe = 1'b0;
        end
    endtask

    task end_dl();
        @(posedge clk_sys);
        #1;
        dl.active = 1'b0;
        dl.strobe = 1'b0;
    endtask

    // Low byte then high byte of the last PRG address
    task queue_pointers();
        exp_t e;
        for (int i = 0; i < 8; i++) begin
            e.wr          = '0;
            e.wr.valid    = 1'b1;
            e.wr.addr     = {7'h00, PTR_ADDR[i]};
            e.wr.data     = (i % 2 == 0) ? ref_prg[7:0] : ref_prg[15:8];
            e.wr.internal = 1'b1;
            e.due         = '0;
            exp_q.push_back(e);
        end
    endtask

    // Bounded wait for the outstanding writes
    task wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 200) begin
            @(posedge clk_sys);
            n++;
        end
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("missing writes at %0t: %0d expected writes never came out",
                     $time, exp_q.size());
            errors++;
        end
        exp_q.delete();
    endtask

    task wait_pulses(input int base, input int expected);
        int n;
        n = 0;
        while (force_count == base && n < 80) begin
            @(posedge clk_sys);
            n++;
        end
        // Window for a second unwanted pulse
        repeat (40) @(posedge clk_sys);
        checks++;
        assert (force_count - base == expected) else begin
            $display("mismatch at %0t: force_reset_o pulsed %0d times, expected %0d",
                     $time, force_count - base, expected);
            errors++;
        end
    endtask

    task report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: fail, %0d errors", name, errors - err0);
        end
    endtask

    // ==================================================
    // Write checker
    // ==================================================
    always @(negedge clk_sys) begin
        if (!reset && mem_wr.valid) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                $display("unexpected write to %h at %0t with nothing left to expect",
                         mem_wr.addr, $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                got = exp_q.pop_front();
                assert (mem_wr.addr == got.wr.addr && mem_wr.data == got.wr.data
                        && mem_wr.internal == got.wr.internal
                        && mem_wr.bank == got.wr.bank) else begin
                    $display("mismatch at %0t: got %h=%h int %b bank %b, exp %h=%h int %b bank %b",
                             $time, mem_wr.addr, mem_wr.data, mem_wr.internal, mem_wr.bank,
                             got.wr.addr, got.wr.data, got.wr.internal, got.wr.bank);
                    errors++;
                end
                assert (got.due == '0 || got.due == cycle) else begin
                    $display("mismatch at %0t: write to %h in cycle %0d, expected cycle %0d",
                             $time, mem_wr.addr, cycle, got.due);
                    errors++;
                end
            end
        end
    end

    initial begin
        repeat (TOTAL_BYTES * 40 + 2000) @(posedge clk_sys);
        $display("timeout: run did not finish in time, %0d writes still expected",
                 exp_q.size());
        $display("TEST FAILED");
        $finish;
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        logic [31:0] r;
        int          err0;
        int          base;
        rng_state = 32'h75c195c3;
        reset     = 1'b1;
        dl        = '0;
        no_header = 1'b0;
        ref_prg   = '0;
        ref_armed = 1'b0;
        cur_kind  = vic_load_pkg::DL_NONE;
        repeat (8) @(posedge clk_sys);
        #1;
        reset = 1'b0;
        @(negedge clk_sys);
        checks++;
        assert (!mem_wr.valid && !force_reset) else begin
            $display("outputs not idle after reset at %0t", $time);
            errors++;
        end

        // ROM regions with fixed samples then random offsets
        err0 = errors;
        start_dl(vic_load_pkg::IDX_ROM, vic_load_pkg::DL_ROM, 1'b0);
        for (int i = 0; i < ROM_FIXED; i++) begin
            r = rand_next();
            send_beat(ROM_OFFS[i], r[7:0]);
        end
        for (int i = 0; i < ROM_BYTES - ROM_FIXED; i++) begin
            r = rand_next();
            send_beat(25'(r % 32'h0000B000), r[31:24]);
        end
        end_dl();
        wait_drain();
        report_test("rom download", err0);

        // PRG loading at $1001
        err0 = errors;
        start_dl(vic_load_pkg::IDX_PRG_A, vic_load_pkg::DL_PRG, 1'b0);
        base = force_count;
        send_beat(25'd0, 8'h01);
        send_beat(25'd1, 8'h10);
        for (int i = 2; i < PRG_HDR_BYTES; i++) begin
            r = rand_next();
            send_beat(25'(i), r[7:0]);
        end
        end_dl();
        queue_pointers();
        wait_drain();
        wait_pulses(base, ref_armed ? 1 : 0);
        report_test("prg with header", err0);

        // PRG from $A000 running into the clamp
        err0 = errors;
        start_dl(vic_load_pkg::IDX_PRG_B, vic_load_pkg::DL_PRG, 1'b1);
        base = force_count;
        for (int i = 0; i < PRG_RAW_BYTES; i++) begin
            r = rand_next();
            send_beat(25'(i), r[7:0]);
        end
        end_dl();
        queue_pointers();
        wait_drain();
        wait_pulses(base, ref_armed ? 1 : 0);
        report_test("prg without header", err0);

        err0 = errors;
        start_dl(vic_load_pkg::IDX_TAP, vic_load_pkg::DL_TAP, 1'b0);
        for (int i = 0; i < TAP_BYTES; i++) begin
            r = rand_next();
            send_beat(25'(i), r[7:0]);
            send_gap(int'(r[9:8]));
        end
        end_dl();
        wait_drain();
        report_test("tap download", err0);

        // Megacart reset pulse 3 cycles after the flag falls
        err0 = errors;
        start_dl(vic_load_pkg::IDX_MEGACART, vic_load_pkg::DL_MC, 1'b0);
        base = force_count;
        for (int i = 0; i < MC_BYTES; i++) begin
            r = rand_next();
            send_beat(25'(i), r[7:0]);
        end
        end_dl();
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        checks++;
        assert (force_reset) else begin
            $display("mismatch at %0t: force_reset_o low 3 cycles after Megacart end", $time);
            errors++;
        end
        wait_drain();
        wait_pulses(base, 1);
        report_test("megacart download", err0);

        err0 = errors;
        start_dl(vic_load_pkg::IDX_TAP, vic_load_pkg::DL_TAP, 1'b0);
        for (int i = 0; i < BURST_BYTES; i++) begin
            r = rand_next();
            send_beat(25'(i), r[15:8]);
        end
        end_dl();
        wait_drain();
        report_test("back-to-back burst", err0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vic_load_pkg.sv ====
/*
 * Download loader definitions
 * Download kinds, the raw request and decoded beat structs,
 * index codes of the file menu and the fixed PRG addresses
 */
package vic_load_pkg;

    // ==================================================
    // Download kinds and stream structs
    // ==================================================
    typedef enum logic [2:0] {
        DL_NONE = 3'd0,
        DL_ROM  = 3'd1,
        DL_PRG  = 3'd2,
        DL_TAP  = 3'd3,
        DL_MC   = 3'd4
    } dl_kind_t;

    // Raw byte stream from the host
    typedef struct packed {
        logic        active;
        logic [7:0]  index;
        logic        strobe;
        logic [24:0] offset;
        logic [7:0]  data;
    } dl_req_t;

    // Byte after classification
    typedef struct packed {
        dl_kind_t    kind;
        logic        strobe;
        logic [24:0] offset;
        logic [7:0]  data;
    } dl_beat_t;

    // ==================================================
    // Index codes and PRG addresses
    // ==================================================
    localparam logic [7:0] IDX_ROM      = 8'h00;
    localparam logic [7:0] IDX_PRG_A    = 8'h01;
    localparam logic [7:0] IDX_PRG_B    = 8'h41;
    localparam logic [7:0] IDX_TAP      = 8'h81;
    localparam logic [7:0] IDX_MEGACART = 8'h02;

    localparam logic [15:0] PRG_NOHDR_BASE = 16'hA000;
    localparam logic [15:0] PRG_LIMIT      = 16'hBFFF;

    // BASIC start/end pointers in zero page, low byte first
    localparam logic [0:7][15:0] INJECT_PTRS = {
        16'h002D, 16'h002E, 16'h002F, 16'h0030,
        16'h0031, 16'h0032, 16'h00AE, 16'h00AF
    };

endpackage

// ==== vic_loader_top.sv ====
/*
 * Download loader top level
 * Three registered stages from host byte stream to memory writes
 */
`timescale 1ns/1ns

module vic_loader_top #(
    parameter logic [mem_port_pkg::MEM_AW-1:0] TAP_START = 23'h20000
) (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  vic_load_pkg::dl_req_t dl_i,
    input  logic                  no_header_i,
    output mem_port_pkg::mem_wr_t mem_wr_o,
    output logic                  force_reset_o
);

    vic_load_pkg::dl_beat_t beat;
    vic_load_pkg::dl_kind_t dl_end;
    mem_port_pkg::mem_wr_t  wr_raw;
    logic                   inject;
    logic                   autostart;
    logic                   mc_end;

    load_decode load_decode_i (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .dl_i     (dl_i),
        .beat_o   (beat),
        .dl_end_o (dl_end)
    );

    load_execute #(
        .TAP_START (TAP_START)
    ) load_execute_i (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .no_header_i (no_header_i),
        .beat_i      (beat),
        .dl_end_i    (dl_end),
        .wr_o        (wr_raw),
        .inject_o    (inject),
        .autostart_o (autostart),
        .mc_end_o    (mc_end)
    );

    load_result load_result_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .wr_i          (wr_raw),
        .inject_i      (inject),
        .autostart_i   (autostart),
        .mc_end_i      (mc_end),
        .mem_wr_o      (mem_wr_o),
        .force_reset_o (force_reset_o)
    );

endmodule
